//--- sim.f
+incdir+hw
hw/wiscIsaPkg.sv
hw/wiscPipePkg.sv
hw/wiscDecode.sv
hw/wiscExecute.sv
hw/wiscResult.sv
hw/wiscCore.sv
test/wiscCore_asserts.sv
test/wiscCoreTb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the core testbench with Verilator
# exits non-zero when the log holds the fail message
set -eo pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
   -f sim.f --top-module wiscCoreTb -o simv

./obj_dir/simv 2>&1 | tee "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
   echo "run failed, see $LOG"
   exit 1
fi

echo "run finished without failure, see $LOG"

//--- test/wiscCoreTb.sv
// self-checking testbench for the two-stage core
// expected reports come from a register-level model and are matched in order
// inputs change on falling edges, outputs are compared on falling edges too
`timescale 1ns/100ps

`include "wisc_params.svh"

module wiscCoreTb import wiscIsaPkg::*; ();

   localparam int resetCycles = 16;
   localparam int numB2b      = 400;           // back-to-back random stream
   localparam int numGap      = 150;           // random stream with idle gaps
   localparam int maxGap      = 3;
   localparam int numDirect   = 200;           // directed ops, reads, drains
   localparam int cycleLimit  =
      (numB2b + numGap * (maxGap + 1) + 2 * resetCycles + numDirect) * 3 / 2;
   localparam int drainLimit  = 8;
   localparam int seed        = 13129;

   localparam logic [1:0] kindWb   = 2'd0;
   localparam logic [1:0] kindErr  = 2'd1;
   localparam logic [1:0] kindNone = 2'd2;
   localparam logic [1:0] kindHalt = 2'd3;

   typedef struct packed {
      logic [1:0]              kind;
      logic [`WISC_REG_W-1:0]  regIdx;
      logic [`WISC_DATA_W-1:0] data;
   } expect_t;

   logic                    clk;
   logic                    reset;
   logic                    instrValid;
   logic [15:0]             instr;
   logic                    wbValid;
   logic [`WISC_REG_W-1:0]  wbReg;
   logic [`WISC_DATA_W-1:0] wbData;
   logic                    errOp;
   logic                    halted;

   logic [`WISC_DATA_W-1:0] modelRegs [`WISC_NREGS];
   logic                    modelHalted;
   logic                    haltSlot;        // next accept is the one behind halt
   logic [`WISC_REG_W-1:0]  lastDest;        // feeds dependent sources
   expect_t                 expQ [$];
   int                      errorCount = 0;
   int                      checkCount = 0;
   int                      cycleCount = 0;

   wiscCore dut0 (
      .clk, .reset, .instrValid, .instr, .wbValid, .wbReg, .wbData, .errOp, .halted
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount >= cycleLimit) begin
         $display("timeout: run did not finish within %0d cycles", cycleLimit);
         $display("Simulation FAILED");
         $finish;
      end
   end

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   // sel follows the ISA order rol, sll, ror, srl
   function automatic logic [15:0] shiftRef(input logic [15:0] v, input logic [1:0] sel,
                                            input logic [3:0] amt);
      logic [31:0] dbl;
      dbl = {v, v};
      case (sel)
         2'b00:   return 16'((dbl << amt) >> 16);   // upper half of doubled word
         2'b01:   return v << amt;
         2'b10:   return 16'(dbl >> amt);
         default: return v >> amt;
      endcase
   endfunction

   function automatic expect_t modelStep(input logic [15:0] ins);
      expect_t     e;
      opcode_e     op;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] imm5s;
      logic [15:0] imm5z;
      logic [16:0] wide;
      op     = opcode_e'(ins[15:11]);
      a      = modelRegs[ins[10:8]];                // rs
      b      = modelRegs[ins[7:5]];                 // rt
      imm5s  = {{11{ins[4]}}, ins[4:0]};
      imm5z  = {11'd0, ins[4:0]};
      wide   = {1'b0, a} + {1'b0, b};
      e.kind = kindWb;
      e.data = '0;
      case (op)
         opAddi:  e.data = a + imm5s;
         opSubi:  e.data = imm5s - a;
         opXori:  e.data = a ^ imm5z;
         opAndni: e.data = a & ~imm5z;
         opRoli, opSlli, opRori, opSrli: e.data = shiftRef(a, ins[12:11], imm5z[3:0]);
         opAluArith: begin
            case (ins[1:0])
               2'b00:   e.data = b + a;
               2'b01:   e.data = b - a;
               2'b10:   e.data = a ^ b;
               default: e.data = a & ~b;
            endcase
         end
         opAluShift: e.data = shiftRef(a, ins[1:0], b[3:0]);
         opSeq:   e.data = {15'd0, a == b};
         opSlt:   e.data = {15'd0, $signed(a) < $signed(b)};
         opSle:   e.data = {15'd0, $signed(a) <= $signed(b)};
         opSco:   e.data = {15'd0, wide[16]};
         opBtr: begin
            for (int i = 0; i < 16; i++) begin
               e.data[i] = a[15-i];
            end
         end
         opLbi:   e.data = {{8{ins[7]}}, ins[7:0]};
         opSlbi:  e.data = {a[7:0], ins[7:0]};
         opNop:   e.kind = kindNone;
         opHalt:  e.kind = kindHalt;
         default: e.kind = kindErr;                 // memory, branch, jump, siic, rti
      endcase
      if (op inside {opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli}) begin
         e.regIdx = ins[7:5];
      end else if (op == opLbi || op == opSlbi) begin
         e.regIdx = ins[10:8];
      end else begin
         e.regIdx = ins[4:2];
      end
      if (modelHalted && !haltSlot) begin
         e.kind = kindNone;                         // nothing retires after halt
      end else if (e.kind == kindWb) begin
         modelRegs[e.regIdx] = e.data;
      end else if (e.kind == kindHalt) begin
         modelHalted = 1'b1;
      end
      haltSlot = (e.kind == kindHalt);
      return e;
   endfunction

   function automatic logic [15:0] immInstr(input opcode_e op, input logic [2:0] rs,
                                            input logic [2:0] rd, input logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic logic [15:0] regInstr(input opcode_e op, input logic [2:0] rs,
                                            input logic [2:0] rt, input logic [2:0] rd,
                                            input logic [1:0] fn);
      return {op, rs, rt, rd, fn};
   endfunction

   function automatic logic [15:0] byteInstr(input opcode_e op, input logic [2:0] rs,
                                             input logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic logic [15:0] randomInstr(input logic [2:0] prevDest);
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      opcode_e    op;
      int         cls;
      rs  = ($urandom_range(1, 0) == 1) ? prevDest : 3'($urandom_range(7, 0));
      rt  = ($urandom_range(1, 0) == 1) ? prevDest : 3'($urandom_range(7, 0));
      rd  = 3'($urandom_range(7, 0));
      cls = $urandom_range(7, 0);
      case (cls)
         0: return regInstr(opAluArith, rs, rt, rd, 2'($urandom_range(3, 0)));
         1: return regInstr(opAluShift, rs, rt, rd, 2'($urandom_range(3, 0)));
         2: begin
            op = opcode_e'({3'b111, 2'($urandom_range(3, 0))}); // seq, slt, sle, sco
            return regInstr(op, rs, rt, rd, 2'd0);
         end
         3: return regInstr(opBtr, rs, rt, rd, 2'd0);
         4: return byteInstr(opLbi, rd, 8'($urandom()));
         5: return byteInstr(opSlbi, rs, 8'($urandom()));      // rs is also dest
         6: begin
            op = opcode_e'({($urandom_range(1, 0) == 1) ? 3'b010 : 3'b101,
                            2'($urandom_range(3, 0))});         // the eight imm ALU ops
            return immInstr(op, rs, rd, 5'($urandom()));
         end
         default: return immInstr(opNop, rs, rd, 5'd0);
      endcase
   endfunction

   // called on a falling edge, returns on the next one
   task automatic sendInstr(input logic [15:0] ins);
      expect_t e;
      instr      = ins;
      instrValid = 1'b1;
      e          = modelStep(ins);
      if (e.kind == kindWb || e.kind == kindErr) begin
         expQ.push_back(e);
      end
      if (e.kind == kindWb) begin
         lastDest = e.regIdx;
      end
      @(negedge clk);
      instrValid = 1'b0;
   endtask

   task automatic idleCycles(input int n);
      repeat (n) begin
         instrValid = 1'b0;
         instr      = 16'($urandom());              // garbage, must be ignored
         haltSlot   = 1'b0;                         // slot behind halt left empty
         @(negedge clk);
      end
   endtask

   // addi rd = rs + 0 reports each register
   task automatic readRegs();
      for (int i = 0; i < `WISC_NREGS; i++) begin
         sendInstr(immInstr(opAddi, 3'(i), 3'(i), 5'd0));
      end
   endtask

   task automatic waitDrain();
      int n;
      n = 0;
      while (expQ.size() != 0 && n < drainLimit) begin
         @(negedge clk);
         n++;
      end
      idleCycles(2);                                // catch late extra reports
   endtask

   task automatic applyReset();
      reset      = 1'b1;
      instrValid = 1'b0;
      repeat (resetCycles) @(negedge clk);
      reset = 1'b0;
      for (int i = 0; i < `WISC_NREGS; i++) begin
         modelRegs[i] = '0;
      end
      modelHalted = 1'b0;
      haltSlot    = 1'b0;
      checkValue("wbValid", 32'(wbValid), 32'd0);
      checkValue("errOp", 32'(errOp), 32'd0);
      checkValue("halted", 32'(halted), 32'd0);
   endtask

   // one queue entry per reported slot, in acceptance order
   always @(negedge clk) begin : compare
      expect_t e;
      if (wbValid || errOp) begin
         if (expQ.size() == 0) begin
            errorCount++;
            $display("unexpected report from the core at %0t with nothing outstanding", $time);
         end else begin
            e = expQ.pop_front();
            checkValue("wbValid", 32'(wbValid), 32'(e.kind == kindWb));
            checkValue("errOp", 32'(errOp), 32'(e.kind == kindErr));
            if (e.kind == kindWb) begin
               checkValue("wbReg", 32'(wbReg), 32'(e.regIdx));
               checkValue("wbData", 32'(wbData), 32'(e.data));
            end
         end
      end
   end

   initial begin
      opcode_e    immOps [8]    = '{opAddi, opSubi, opXori, opAndni,
                                    opRoli, opSlli, opRori, opSrli};
      logic [4:0] immVals [6]   = '{5'h00, 5'h01, 5'h0f, 5'h10, 5'h1b, 5'h1f};
      opcode_e    rejected [13] = '{opSiic, opRti, opJ, opJr, opJal, opJalr, opBeqz,
                                    opBnez, opBltz, opBgez, opSt, opLd, opStu};
      void'($urandom(seed));
      reset       = 1'b1;
      instrValid  = 1'b0;
      instr       = '0;
      lastDest    = '0;
      modelHalted = 1'b0;
      haltSlot    = 1'b0;
      applyReset();
      readRegs();                                   // all zero after reset
      for (int i = 0; i < `WISC_NREGS; i++) begin
         sendInstr(byteInstr(opLbi, 3'(i), 8'($urandom())));
      end
      for (int o = 0; o < 8; o++) begin             // imm5 extension, both signs
         for (int k = 0; k < 6; k++) begin
            sendInstr(immInstr(immOps[o], 3'(k), 3'(k + o), immVals[k]));
         end
      end
      for (int i = 0; i < numB2b; i++) begin
         sendInstr(randomInstr(lastDest));
      end
      for (int i = 0; i < numGap; i++) begin
         sendInstr(randomInstr(lastDest));
         idleCycles($urandom_range(maxGap, 0));
      end
      waitDrain();
      for (int i = 0; i < 13; i++) begin
         sendInstr({rejected[i], 11'($urandom())});
      end
      readRegs();                                   // unchanged by rejected ops
      waitDrain();
      sendInstr(immInstr(opHalt, 3'd0, 3'd0, 5'd0));
      repeat (3) sendInstr(randomInstr(lastDest));  // first one still retires
      while (halted !== 1'b1) @(negedge clk);
      repeat (4) sendInstr(randomInstr(lastDest));
      idleCycles(4);
      checkValue("halted", 32'(halted), 32'd1);
      waitDrain();
      applyReset();                                 // clears halt and the file
      readRegs();
      waitDrain();
      if (expQ.size() != 0) begin
         errorCount++;
         $display("%0d expected reports never arrived", expQ.size());
      end
      $display("errors: %0d in %0d checks", errorCount, checkCount);
      if (errorCount == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

//--- test/wiscCore_asserts.sv
// port-level protocol checks, bound into every wiscCore instance
// all properties are off while reset is high
`timescale 1ns/100ps

`include "wisc_params.svh"

module wiscCoreAsserts (
   input logic                    clk,
   input logic                    reset,
   input logic                    wbValid,
   input logic                    errOp,
   input logic                    halted,
   input logic [`WISC_REG_W-1:0]  wbReg,
   input logic [`WISC_DATA_W-1:0] wbData
);

   // a slot reports either a writeback or a rejected opcode
   wbErrExclusive: assert property (@(posedge clk) disable iff (reset)
      !(wbValid && errOp))
      else $error("writeback and error reported in the same cycle");

   // halt latch is sticky
   haltSticky: assert property (@(posedge clk) disable iff (reset)
      halted |=> halted)
      else $error("halted dropped before reset");

   // one slot for the instruction behind halt, then silence
   haltSilent: assert property (@(posedge clk) disable iff (reset)
      halted |-> ##2 (!wbValid && !errOp))
      else $error("core reported after halt");

   wbKnown: assert property (@(posedge clk) disable iff (reset)
      wbValid |-> !$isunknown({wbReg, wbData}))
      else $error("writeback register or data unknown");

endmodule

bind wiscCore wiscCoreAsserts asserts0 (
   .clk, .reset, .wbValid, .errOp, .halted, .wbReg, .wbData
);

//--- hw/wiscCore.sv
// two-stage integer core, one instruction per valid strobe, no back-pressure
// writeback reported two edges after acceptance, in order
`timescale 1ns/100ps

`include "wisc_params.svh"

module wiscCore
   import wiscPipePkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    instrValid,
   input  logic [15:0]             instr,
   output logic                    wbValid,
   output logic [`WISC_REG_W-1:0]  wbReg,
   output logic [`WISC_DATA_W-1:0] wbData,
   output logic                    errOp,
   output logic                    halted
);

   decodePkt_t              decPkt;
   resultPkt_t              exPkt;    // also the forwarding path
   logic [`WISC_REG_W-1:0]  rdAddrA;
   logic [`WISC_REG_W-1:0]  rdAddrB;
   logic [`WISC_DATA_W-1:0] rdDataA;
   logic [`WISC_DATA_W-1:0] rdDataB;

   wiscDecode decode0 (
      .clk, .reset, .instrValid, .instr, .halted,
      .rdDataA, .rdDataB, .exPkt,
      .rdAddrA, .rdAddrB, .decPkt
   );

   wiscExecute execute0 (
      .decPkt, .exPkt
   );

   wiscResult result0 (
      .clk, .reset, .exPkt, .rdAddrA, .rdAddrB,
      .rdDataA, .rdDataB, .wbValid, .wbReg, .wbData, .errOp, .halted
   );

endmodule

//--- hw/wiscResult.sv
// register file and writeback report, one cycle after execute
// the instruction behind halt still retires, decode drops the rest until reset
`timescale 1ns/100ps

`include "wisc_params.svh"

module wiscResult
   import wiscPipePkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  resultPkt_t              exPkt,
   input  logic [`WISC_REG_W-1:0]  rdAddrA,
   input  logic [`WISC_REG_W-1:0]  rdAddrB,
   output logic [`WISC_DATA_W-1:0] rdDataA,
   output logic [`WISC_DATA_W-1:0] rdDataB,
   output logic                    wbValid,
   output logic [`WISC_REG_W-1:0]  wbReg,
   output logic [`WISC_DATA_W-1:0] wbData,
   output logic                    errOp,
   output logic                    halted
);

   logic [`WISC_DATA_W-1:0] regFile [`WISC_NREGS];
   logic                    accept;

   assign accept  = exPkt.valid;             // decode already gates on halted
   assign rdDataA = regFile[rdAddrA];        // async read, written value next cycle
   assign rdDataB = regFile[rdAddrB];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `WISC_NREGS; i++) begin
            regFile[i] <= '0;
         end
      end else if (accept & exPkt.regWrt) begin
         regFile[exPkt.destReg] <= exPkt.data;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wbValid <= 1'b0;
         errOp   <= 1'b0;
         halted  <= 1'b0;
      end else begin
         wbValid <= accept & exPkt.regWrt;
         errOp   <= accept & exPkt.errOp;       // one cycle pulse
         halted  <= halted | (accept & exPkt.halt); // sticky
      end
   end

   // report payload, qualified by wbValid
   always_ff @(posedge clk) begin
      wbReg  <= exPkt.destReg;
      wbData <= exPkt.data;
   end

endmodule

//--- hw/wiscExecute.sv
// second stage datapath, purely combinational
// shifts and rotates use only the low four bits of operand b
// set ops produce 0 or 1 from the adder flags
`timescale 1ns/100ps

`include "wisc_params.svh"

module wiscExecute
   import wiscPipePkg::*;
(
   input  decodePkt_t decPkt,
   output resultPkt_t exPkt
);

   localparam int DW = `WISC_DATA_W;

   ctrl_t          ctrl;
   logic [DW-1:0]  opA;
   logic [DW-1:0]  bSel;
   logic [DW-1:0]  aIn;
   logic [DW-1:0]  bIn;
   logic [DW-1:0]  sum;
   logic           cout;
   logic           zero;
   logic           sign;
   logic           ovf;
   logic [3:0]     shAmt;
   logic [DW-1:0]  rev;
   logic [DW-1:0]  aluRes;
   logic           setBit;

   assign ctrl = decPkt.ctrl;
   assign opA  = decPkt.operandA;
   assign bSel = ctrl.bSrcImm ? decPkt.imm : decPkt.operandB; // reg or imm

   // inverting adder
   assign aIn           = ctrl.invA ? ~opA : opA;
   assign bIn           = ctrl.invB ? ~bSel : bSel;
   assign {cout, sum}   = {1'b0, aIn} + {1'b0, bIn} + {{DW{1'b0}}, ctrl.cin};
   assign zero          = (sum == '0);
   assign sign          = sum[DW-1];
   assign ovf           = (aIn[DW-1] == bIn[DW-1]) & (sum[DW-1] != aIn[DW-1]);

   assign shAmt = bSel[3:0];

   always_comb begin
      for (int i = 0; i < DW; i++) begin
         rev[i] = opA[DW-1-i];
      end
   end

   always_comb begin
      case (ctrl.aluOp)
         aluAdd:   aluRes = sum;
         aluXor:   aluRes = aIn ^ bIn;
         aluAndn:  aluRes = aIn & bIn;                   // b inverted by decode
         aluRol:   aluRes = (opA << shAmt) | (opA >> (5'd16 - {1'b0, shAmt}));
         aluSll:   aluRes = opA << shAmt;
         aluRor:   aluRes = (opA >> shAmt) | (opA << (5'd16 - {1'b0, shAmt}));
         aluSrl:   aluRes = opA >> shAmt;
         aluBtr:   aluRes = rev;
         aluPassB: aluRes = bSel;
         aluSlbi:  aluRes = {opA[DW-9:0], 8'h00} | bSel;
         default:  aluRes = sum;
      endcase
   end

   // adder holds b - a for eq, lt, le and a + b for carry
   always_comb begin
      case (ctrl.setCond)
         condEq:    setBit = zero;
         condLt:    setBit = ~zero & ~(sign ^ ovf);      // b - a > 0
         condLe:    setBit = ~(sign ^ ovf);              // b - a >= 0
         condCarry: setBit = cout;
         default:   setBit = 1'b0;
      endcase
   end

   always_comb begin
      exPkt.valid   = decPkt.valid;
      exPkt.regWrt  = ctrl.regWrt;
      exPkt.errOp   = ctrl.errOp;
      exPkt.halt    = ctrl.halt;
      exPkt.destReg = decPkt.destReg;
      exPkt.data    = (ctrl.setCond == condNone) ? aluRes : {{(DW-1){1'b0}}, setBit};
   end

endmodule

//--- hw/wiscDecode.sv
// first stage: opcode decode, operand fetch with one forwarding path
// operands forward only from the packet in execute; older ones are in the file
// rejected opcodes set errOp and never write a register
`timescale 1ns/100ps

`include "wisc_params.svh"

module wiscDecode
   import wiscIsaPkg::*, wiscPipePkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    instrValid,
   input  logic [15:0]             instr,
   input  logic                    halted,   // drop everything once set
   input  logic [`WISC_DATA_W-1:0] rdDataA,
   input  logic [`WISC_DATA_W-1:0] rdDataB,
   input  resultPkt_t              exPkt,    // forwarding source
   output logic [`WISC_REG_W-1:0]  rdAddrA,
   output logic [`WISC_REG_W-1:0]  rdAddrB,
   output decodePkt_t              decPkt
);

   opcode_e                 opc;
   aluFunc_e                func;
   ctrl_t                   ctrl;
   logic [`WISC_REG_W-1:0]  destReg;
   logic [`WISC_DATA_W-1:0] imm;
   logic                    fwdA;
   logic                    fwdB;
   decodePkt_t              decNext;

   // same order for immediate and register shift forms
   function automatic aluOp_e shiftOp(input logic [1:0] sel);
      case (sel)
         2'b00:   return aluRol;
         2'b01:   return aluSll;
         2'b10:   return aluRor;
         default: return aluSrl;
      endcase
   endfunction

   assign opc  = opcode_e'(instr[15:11]);
   assign func = aluFunc_e'(instr[1:0]);

   always_comb begin
      ctrl    = '0;                                      // add, no set, no write
      destReg = instr[7:5];                              // immediate format
      imm     = {{(`WISC_DATA_W-5){instr[4]}}, instr[4:0]}; // sext imm5
      case (opc)
         opHalt: ctrl.halt = 1'b1;
         opNop: ;                                        // nothing, no report
         opAddi: begin
            ctrl.regWrt  = 1'b1;
            ctrl.bSrcImm = 1'b1;
         end
         opSubi: begin
            ctrl.regWrt  = 1'b1;
            ctrl.bSrcImm = 1'b1;
            ctrl.invA    = 1'b1;                          // imm - rs
            ctrl.cin     = 1'b1;
         end
         opXori, opAndni: begin
            ctrl.regWrt  = 1'b1;
            ctrl.bSrcImm = 1'b1;
            ctrl.aluOp   = (opc == opXori) ? aluXor : aluAndn;
            ctrl.invB    = (opc == opAndni);
            imm          = {{(`WISC_DATA_W-5){1'b0}}, instr[4:0]}; // zext
         end
         opRoli, opSlli, opRori, opSrli: begin
            ctrl.regWrt  = 1'b1;
            ctrl.bSrcImm = 1'b1;
            ctrl.aluOp   = shiftOp(instr[12:11]);
            imm          = {{(`WISC_DATA_W-5){1'b0}}, instr[4:0]};
         end
         opAluArith: begin
            ctrl.regWrt = 1'b1;
            destReg     = instr[4:2];
            case (func)
               fnAddRol: ctrl.aluOp = aluAdd;
               fnSubSll: begin
                  ctrl.invA = 1'b1;                       // rt - rs
                  ctrl.cin  = 1'b1;
               end
               fnXorRor: ctrl.aluOp = aluXor;
               default: begin
                  ctrl.aluOp = aluAndn;
                  ctrl.invB  = 1'b1;
               end
            endcase
         end
         opAluShift: begin
            ctrl.regWrt = 1'b1;
            destReg     = instr[4:2];
            ctrl.aluOp  = shiftOp(func);
         end
         opSeq, opSlt, opSle: begin
            ctrl.regWrt  = 1'b1;
            destReg      = instr[4:2];
            ctrl.invA    = 1'b1;                          // flags from rt - rs
            ctrl.cin     = 1'b1;
            ctrl.setCond = (opc == opSeq) ? condEq : (opc == opSlt) ? condLt : condLe;
         end
         opSco: begin
            ctrl.regWrt  = 1'b1;
            destReg      = instr[4:2];
            ctrl.setCond = condCarry;                     // carry of rs + rt
         end
         opBtr: begin
            ctrl.regWrt = 1'b1;
            destReg     = instr[4:2];
            ctrl.aluOp  = aluBtr;
         end
         opLbi, opSlbi: begin
            ctrl.regWrt  = 1'b1;
            ctrl.bSrcImm = 1'b1;
            destReg      = instr[10:8];
            ctrl.aluOp   = (opc == opLbi) ? aluPassB : aluSlbi;
            imm          = (opc == opLbi) ?
                           {{(`WISC_DATA_W-8){instr[7]}}, instr[7:0]} :
                           {{(`WISC_DATA_W-8){1'b0}}, instr[7:0]};
         end
         default: ctrl.errOp = 1'b1;                      // memory, branch, jump, siic, rti
      endcase
   end

   // register file read plus bypass from the instruction in execute
   assign rdAddrA = instr[10:8];
   assign rdAddrB = instr[7:5];
   assign fwdA    = exPkt.valid & exPkt.regWrt & (exPkt.destReg == rdAddrA);
   assign fwdB    = exPkt.valid & exPkt.regWrt & (exPkt.destReg == rdAddrB);

   always_comb begin
      decNext.valid    = instrValid & ~halted;
      decNext.ctrl     = ctrl;
      decNext.operandA = fwdA ? exPkt.data : rdDataA;
      decNext.operandB = fwdB ? exPkt.data : rdDataB;
      decNext.destReg  = destReg;
      decNext.imm      = imm;
   end

   always_ff @(posedge clk) begin
      decPkt <= decNext;
      if (reset) begin
         decPkt.valid <= 1'b0;                            // payload left as is
      end
   end

endmodule

//--- hw/wiscPipePkg.sv
// packets passed between decode, execute and result
// widths come from the shared params header
package wiscPipePkg;

`include "wisc_params.svh"

   typedef enum logic [3:0] {
      aluAdd,   // inverting adder output
      aluXor,
      aluAndn,  // a & b, b already inverted by invB
      aluRol,
      aluSll,
      aluRor,
      aluSrl,
      aluBtr,   // bit reverse of a
      aluPassB, // lbi
      aluSlbi   // (a << 8) | b
   } aluOp_e;

   typedef enum logic [2:0] {
      condNone,
      condEq,
      condLt,
      condLe,
      condCarry
   } setCond_e;

   typedef struct packed {
      aluOp_e   aluOp;
      logic     invA;
      logic     invB;
      logic     cin;
      setCond_e setCond;
      logic     regWrt;
      logic     errOp;    // rejected opcode
      logic     halt;
      logic     bSrcImm;  // operand b from immediate
   } ctrl_t;

   typedef struct packed {
      logic                    valid;
      ctrl_t                   ctrl;
      logic [`WISC_DATA_W-1:0] operandA;
      logic [`WISC_DATA_W-1:0] operandB;
      logic [`WISC_REG_W-1:0]  destReg;
      logic [`WISC_DATA_W-1:0] imm;      // already extended
   } decodePkt_t;

   typedef struct packed {
      logic                    valid;
      logic                    regWrt;
      logic                    errOp;
      logic                    halt;
      logic [`WISC_REG_W-1:0]  destReg;
      logic [`WISC_DATA_W-1:0] data;
   } resultPkt_t;

endpackage

//--- hw/wiscIsaPkg.sv
// instruction set encodings as seen in instr[15:11] and instr[1:0]
// every opcode is named, including those the core rejects
package wiscIsaPkg;

   typedef enum logic [4:0] {
      opHalt     = 5'b0_0000,
      opNop      = 5'b0_0001,
      opSiic     = 5'b0_0010,
      opRti      = 5'b0_0011,
      opJ        = 5'b0_0100,
      opJr       = 5'b0_0101,
      opJal      = 5'b0_0110,
      opJalr     = 5'b0_0111,
      opAddi     = 5'b0_1000,
      opSubi     = 5'b0_1001,
      opXori     = 5'b0_1010,
      opAndni    = 5'b0_1011,
      opBeqz     = 5'b0_1100,
      opBnez     = 5'b0_1101,
      opBltz     = 5'b0_1110,
      opBgez     = 5'b0_1111,
      opSt       = 5'b1_0000,
      opLd       = 5'b1_0001,
      opSlbi     = 5'b1_0010,
      opStu      = 5'b1_0011,
      opRoli     = 5'b1_0100, // low two bits follow the shift func order
      opSlli     = 5'b1_0101,
      opRori     = 5'b1_0110,
      opSrli     = 5'b1_0111,
      opLbi      = 5'b1_1000,
      opBtr      = 5'b1_1001,
      opAluShift = 5'b1_1010, // ROL, SLL, ROR, SRL by func
      opAluArith = 5'b1_1011, // ADD, SUB, XOR, ANDN by func
      opSeq      = 5'b1_1100,
      opSlt      = 5'b1_1101,
      opSle      = 5'b1_1110,
      opSco      = 5'b1_1111
   } opcode_e;

   // meaning depends on opcode: arith name first, shift name second
   typedef enum logic [1:0] {
      fnAddRol  = 2'b00,
      fnSubSll  = 2'b01,
      fnXorRor  = 2'b10,
      fnAndnSrl = 2'b11
   } aluFunc_e;

endpackage

//--- hw/wisc_params.svh
// core-wide sizes for the 16-bit teaching ISA
// register index width must match the register count
`ifndef WISC_PARAMS_SVH
`define WISC_PARAMS_SVH

// one machine word, also the instruction width
`define WISC_DATA_W 16

// architectural register file
`define WISC_NREGS 8
`define WISC_REG_W 3

`endif
